//--- logic/mipsPkg.sv
`default_nettype none

package mipsPkg;

  ////////////////////////////////////////////////////////////
  // widths fixed by the ISA
  ////////////////////////////////////////////////////////////
  localparam int dataWidth = 32;

  typedef logic [4:0]           regIdx_t;  // register index
  typedef logic [dataWidth-1:0] word_t;    // data word

  ////////////////////////////////////////////////////////////
  // encodings
  ////////////////////////////////////////////////////////////
  typedef enum logic [5:0] {
    opSpecial  = 6'b000000,  // r type and jr
    opRegImm   = 6'b000001,  // bgez, bltz
    opJ        = 6'b000010,
    opJal      = 6'b000011,
    opBeq      = 6'b000100,
    opBne      = 6'b000101,
    opBlez     = 6'b000110,
    opBgtz     = 6'b000111,
    opAddi     = 6'b001000,
    opSlti     = 6'b001010,
    opAndi     = 6'b001100,
    opOri      = 6'b001101,
    opXori     = 6'b001110,
    opSpecial2 = 6'b011100,  // mul
    opLb       = 6'b100000,
    opLh       = 6'b100001,
    opLw       = 6'b100011,
    opSb       = 6'b101000,
    opSh       = 6'b101001,
    opSw       = 6'b101011
  } opcode_t;

  typedef enum logic [3:0] {
    aluAdd   = 4'b0000,  // address calc
    aluAddi  = 4'b0001,
    aluRType = 4'b0010,  // op picked by funct
    aluBgez  = 4'b0011,
    aluBeq   = 4'b0100,
    aluBne   = 4'b0101,
    aluBgtz  = 4'b0110,
    aluBlez  = 4'b0111,
    aluBltz  = 4'b1000,
    aluPass  = 4'b1001,  // jumps, a goes straight out
    aluAnd   = 4'b1010,
    aluOr    = 4'b1011,
    aluXor   = 4'b1100,
    aluSlt   = 4'b1101,
    aluMul   = 4'b1111
  } aluOp_t;

  typedef enum logic [1:0] {
    brNone    = 2'd0,
    brJump    = 2'd1,
    brJumpReg = 2'd2,
    brCond    = 2'd3
  } branch_t;

  typedef enum logic [1:0] {
    sizeByte = 2'd0,
    sizeHalf = 2'd1,
    sizeWord = 2'd2
  } memSize_t;

  // r type function field
  localparam logic [5:0] functJr  = 6'b001000;
  localparam logic [5:0] functAdd = 6'b100000;
  localparam logic [5:0] functSub = 6'b100010;
  localparam logic [5:0] functAnd = 6'b100100;
  localparam logic [5:0] functOr  = 6'b100101;
  localparam logic [5:0] functXor = 6'b100110;
  localparam logic [5:0] functSlt = 6'b101010;

endpackage

`default_nettype wire

//--- logic/controller.sv
`timescale 1ns/1ps
`default_nettype none

module controller (
  input  mipsPkg::opcode_t  opcode,
  input  logic [5:0]        funct,       // only consulted for jr
  input  logic [4:0]        regImm,      // bgez vs bltz
  output logic              regDst,      // rd instead of rt
  output logic              memRead,
  output logic              memToReg,    // write back load data
  output mipsPkg::aluOp_t   aluOp,
  output logic              memWrite,
  output logic              aluSrc,      // immediate on alu b
  output logic              regWrite,
  output mipsPkg::branch_t  branchType,
  output mipsPkg::memSize_t memSize,
  output logic              link         // jal return address
);
  import mipsPkg::*;

  always_comb begin
    regDst     = 1'b0;  // everything idle by default
    memRead    = 1'b0;
    memToReg   = 1'b0;
    memWrite   = 1'b0;
    aluSrc     = 1'b0;
    regWrite   = 1'b0;
    link       = 1'b0;
    aluOp      = aluAdd;
    branchType = brNone;
    memSize    = sizeWord;

    case (opcode)
      opSpecial: begin
        if (funct == functJr) begin
          aluOp      = aluPass;
          branchType = brJumpReg;  // no register write
        end else begin
          regDst   = 1'b1;
          regWrite = 1'b1;
          aluOp    = aluRType;
        end
      end
      opSpecial2: begin
        regDst   = 1'b1;
        regWrite = 1'b1;
        aluOp    = aluMul;
      end
      opAddi, opAndi, opOri, opXori, opSlti: begin
        aluSrc   = 1'b1;
        regWrite = 1'b1;
        case (opcode)
          opAndi:  aluOp = aluAnd;
          opOri:   aluOp = aluOr;
          opXori:  aluOp = aluXor;
          opSlti:  aluOp = aluSlt;
          default: aluOp = aluAddi;
        endcase
      end
      opLb, opLh, opLw: begin
        memRead  = 1'b1;
        memToReg = 1'b1;
        aluSrc   = 1'b1;
        regWrite = 1'b1;
      end
      opSb, opSh, opSw: begin
        memWrite = 1'b1;
        aluSrc   = 1'b1;
      end
      opRegImm: begin
        if (regImm == 5'b00001) begin
          aluOp      = aluBgez;
          branchType = brCond;
        end else if (regImm == 5'b00000) begin
          aluOp      = aluBltz;
          branchType = brCond;
        end
      end
      opBeq, opBne, opBgtz, opBlez: begin
        branchType = brCond;
        case (opcode)
          opBeq:   aluOp = aluBeq;
          opBne:   aluOp = aluBne;
          opBgtz:  aluOp = aluBgtz;
          default: aluOp = aluBlez;
        endcase
      end
      opJ: begin
        aluOp      = aluPass;
        branchType = brJump;
      end
      opJal: begin
        aluOp      = aluPass;
        branchType = brJump;
        regWrite   = 1'b1;
        link       = 1'b1;  // rd forced to 31 in the core
      end
      default: ;  // unknown opcode stays idle
    endcase

    // size sits in the low opcode bits: x00 byte, x01 half, x11 word
    if (memRead || memWrite) begin
      memSize = opcode[1] ? sizeWord : (opcode[0] ? sizeHalf : sizeByte);
    end
  end

endmodule

`default_nettype wire

//--- logic/aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
  input  mipsPkg::word_t  a,
  input  mipsPkg::word_t  b,
  input  mipsPkg::aluOp_t aluOp,
  input  logic [5:0]      funct,
  output mipsPkg::word_t  result,
  output logic            taken    // branch condition met
);
  import mipsPkg::*;

  logic aIsZero;
  logic aIsNeg;
  logic sltFlag;

  assign aIsZero = (a == '0);
  assign aIsNeg  = a[dataWidth-1];  // signed compare against zero
  assign sltFlag = ($signed(a) < $signed(b));

  ////////////////////////////////////////////////////////////
  // result
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (aluOp)
      aluAdd, aluAddi: result = a + b;
      aluAnd:          result = a & b;
      aluOr:           result = a | b;
      aluXor:          result = a ^ b;
      aluSlt:          result = {{(dataWidth-1){1'b0}}, sltFlag};
      aluMul:          result = a * b;  // low word, same for signed
      aluRType: begin
        case (funct)
          functAdd: result = a + b;
          functSub: result = a - b;
          functAnd: result = a & b;
          functOr:  result = a | b;
          functXor: result = a ^ b;
          functSlt: result = {{(dataWidth-1){1'b0}}, sltFlag};
          default:  result = '0;
        endcase
      end
      default:         result = a;  // pass, branches
    endcase
  end

  ////////////////////////////////////////////////////////////
  // branch condition
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (aluOp)
      aluBeq:  taken = (a == b);
      aluBne:  taken = (a != b);
      aluBgez: taken = !aIsNeg;
      aluBgtz: taken = !aIsNeg && !aIsZero;
      aluBlez: taken = aIsNeg || aIsZero;
      aluBltz: taken = aIsNeg;
      default: taken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
  input  logic             clk,
  input  logic             rstN,
  input  mipsPkg::regIdx_t rs,
  input  mipsPkg::regIdx_t rt,
  input  mipsPkg::regIdx_t wrReg,
  input  logic             wrEn,
  input  mipsPkg::word_t   wrData,
  output mipsPkg::word_t   rsData,
  output mipsPkg::word_t   rtData
);
  import mipsPkg::*;

  word_t regs [32];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn && (wrReg != '0)) begin  // r0 never written
      regs[wrReg] <= wrData;
    end
  end

  assign rsData = regs[rs];  // async read, old value until edge
  assign rtData = regs[rt];

  // r0 stays zero across every write
  assert property (@(posedge clk) disable iff (!rstN) (rs == '0) |-> (rsData == '0))
    else $error("register 0 not zero");

endmodule

`default_nettype wire

//--- logic/dataMem.sv
`timescale 1ns/1ps
`default_nettype none

module dataMem #(
  parameter int memWords = 256
) (
  input  logic              clk,
  input  mipsPkg::word_t    addr,
  input  mipsPkg::word_t    writeData,
  input  logic              memRead,
  input  logic              memWrite,
  input  mipsPkg::memSize_t memSize,
  output mipsPkg::word_t    readData
);
  import mipsPkg::*;

  localparam int idxW = $clog2(memWords);

  logic [3:0][7:0]  ram [memWords];  // four byte lanes, little endian
  logic [idxW-1:0]  wordIdx;
  logic [1:0]       lane;
  logic [3:0][7:0]  ramWord;
  logic [15:0]      loadHalf;

  assign wordIdx  = addr[idxW+1:2];
  assign lane     = addr[1:0];
  assign ramWord  = ram[wordIdx];
  assign loadHalf = lane[1] ? {ramWord[3], ramWord[2]} : {ramWord[1], ramWord[0]};

  always_ff @(posedge clk) begin
    if (memWrite) begin
      case (memSize)
        sizeByte: ram[wordIdx][lane] <= writeData[7:0];
        sizeHalf: begin
          ram[wordIdx][{lane[1], 1'b0}] <= writeData[7:0];
          ram[wordIdx][{lane[1], 1'b1}] <= writeData[15:8];
        end
        default:  ram[wordIdx] <= writeData;
      endcase
    end
  end

  always_comb begin
    if (!memRead) begin
      readData = '0;
    end else begin
      case (memSize)
        sizeByte: readData = {{24{ramWord[lane][7]}}, ramWord[lane]};  // sign extend
        sizeHalf: readData = {{16{loadHalf[15]}}, loadHalf};
        default:  readData = ramWord;
      endcase
    end
  end

  assert property (@(posedge clk) (memRead || memWrite) && (memSize == sizeHalf)
                   |-> (addr[0] == 1'b0))
    else $error("unaligned halfword access");
  assert property (@(posedge clk) (memRead || memWrite) && (memSize == sizeWord)
                   |-> (addr[1:0] == 2'b00))
    else $error("unaligned word access");

endmodule

`default_nettype wire

//--- logic/pcUnit.sv
`timescale 1ns/1ps
`default_nettype none

module pcUnit (
  input  logic             clk,
  input  logic             rstN,
  input  mipsPkg::branch_t branchType,
  input  logic             taken,
  input  mipsPkg::word_t   imm,        // already sign extended
  input  logic [25:0]      jumpIndex,
  input  mipsPkg::word_t   rsData,
  output mipsPkg::word_t   pc,
  output mipsPkg::word_t   pcPlus4
);
  import mipsPkg::*;

  word_t branchTarget;
  word_t jumpTarget;
  word_t nextPc;

  assign pcPlus4      = pc + 32'd4;
  assign branchTarget = pcPlus4 + {imm[dataWidth-3:0], 2'b00};  // word offset
  assign jumpTarget   = {pcPlus4[31:28], jumpIndex, 2'b00};     // same 256MB region

  always_comb begin
    case (branchType)
      brCond:    nextPc = taken ? branchTarget : pcPlus4;
      brJump:    nextPc = jumpTarget;
      brJumpReg: nextPc = rsData;
      default:   nextPc = pcPlus4;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // pc register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc <= '0;
    end else begin
      pc <= nextPc;
    end
  end

endmodule

`default_nettype wire

//--- logic/mipsCore.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCore #(
  parameter int memWords = 256
) (
  input  logic             clk,
  input  logic             rstN,
  input  mipsPkg::word_t   instr,   // from fetch, answers pc
  output mipsPkg::word_t   pc,
  output logic             wbEn,
  output mipsPkg::regIdx_t wbReg,
  output mipsPkg::word_t   wbData
);
  import mipsPkg::*;

  opcode_t  opcode;
  logic     regDst, memRead, memToReg, memWrite, aluSrc, regWrite, link;
  aluOp_t   aluOp;
  branch_t  branchType;
  memSize_t memSize;
  word_t    rsData, rtData, immExt, aluB, aluResult, readData, pcPlus4;
  logic     taken;
  logic     zeroExt;

  assign opcode = opcode_t'(instr[31:26]);

  controller u_ctrl (
    .opcode(opcode), .funct(instr[5:0]), .regImm(instr[20:16]),
    .regDst(regDst), .memRead(memRead), .memToReg(memToReg), .aluOp(aluOp),
    .memWrite(memWrite), .aluSrc(aluSrc), .regWrite(regWrite),
    .branchType(branchType), .memSize(memSize), .link(link)
  );

  ////////////////////////////////////////////////////////////
  // operand selection
  ////////////////////////////////////////////////////////////
  assign zeroExt = (aluOp == aluAnd) || (aluOp == aluOr) || (aluOp == aluXor);  // logic imm
  assign immExt  = zeroExt ? {16'b0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};
  assign aluB    = aluSrc ? immExt : rtData;

  regFile u_regs (
    .clk(clk), .rstN(rstN), .rs(instr[25:21]), .rt(instr[20:16]),
    .wrReg(wbReg), .wrEn(wbEn), .wrData(wbData), .rsData(rsData), .rtData(rtData)
  );

  aluUnit u_alu (
    .a(rsData), .b(aluB), .aluOp(aluOp), .funct(instr[5:0]),
    .result(aluResult), .taken(taken)
  );

  dataMem #(.memWords(memWords)) u_dmem (
    .clk(clk), .addr(aluResult), .writeData(rtData), .memRead(memRead),
    .memWrite(memWrite), .memSize(memSize), .readData(readData)
  );

  pcUnit u_pc (
    .clk(clk), .rstN(rstN), .branchType(branchType), .taken(taken), .imm(immExt),
    .jumpIndex(instr[25:0]), .rsData(rsData), .pc(pc), .pcPlus4(pcPlus4)
  );

  ////////////////////////////////////////////////////////////
  // write back
  ////////////////////////////////////////////////////////////
  assign wbEn   = regWrite;
  assign wbReg  = link ? 5'd31 : (regDst ? instr[15:11] : instr[20:16]);  // jal to ra
  assign wbData = link ? pcPlus4 : (memToReg ? readData : aluResult);

endmodule

`default_nettype wire

//--- test/mipsCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCoreTb;
  import mipsPkg::*;

  localparam word_t      idleInstr = 32'hFC00_0000;  // opcode 111111, decodes idle
  localparam logic [5:0] functMul  = 6'b000010;

  logic    clk;
  logic    rstN;
  word_t   instr;
  word_t   pc;
  logic    wbEn;
  regIdx_t wbReg;
  word_t   wbData;

  word_t       refRegs [32];    // expected register contents
  logic [7:0]  memRef  [1024];  // expected data bytes, little endian lanes
  logic [15:0] lfsr;

  mipsCore #(.memWords(256)) i_dut (
    .clk(clk), .rstN(rstN), .instr(instr), .pc(pc),
    .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData)
  );

  always #10 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////
  function automatic logic lfsrStep();
    logic fb;
    fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];  // x^16+x^14+x^13+x^11+1
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic logic [15:0] randHalf();
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < 16; i++) begin
      v = {v[14:0], lfsrStep()};  // one step per bit
    end
    return v;
  endfunction

  function automatic word_t randWord();
    word_t v;
    v[31:16] = randHalf();
    v[15:0]  = randHalf();
    return v;
  endfunction

  function automatic word_t encR(opcode_t op, regIdx_t rs, regIdx_t rt, regIdx_t rd,
                                 logic [5:0] fn);
    return {op, rs, rt, rd, 5'b00000, fn};
  endfunction

  function automatic word_t encI(opcode_t op, regIdx_t rs, regIdx_t rt, logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t encJ(opcode_t op, logic [25:0] index);
    return {op, index};
  endfunction

  ////////////////////////////////////////////////////////////
  // checking
  ////////////////////////////////////////////////////////////
  task automatic abortRun(string line);
    $display("%s", line);
    $display("Something failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic checkWord(word_t got, word_t exp, string what);
    if (got !== exp) begin
      abortRun($sformatf("FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  task automatic checkReg(regIdx_t got, regIdx_t exp, string what);
    if (got !== exp) begin
      abortRun($sformatf("FAILED at %0t ns: %s got r%0d expected r%0d", $time, what, got, exp));
    end
  endtask

  task automatic checkBit(logic got, logic exp, string what);
    if (got !== exp) begin
      abortRun($sformatf("FAILED at %0t ns: %s got %b expected %b", $time, what, got, exp));
    end
  endtask

  task automatic waitForPc(word_t target, int limit);
    int n;
    n = 0;
    while ((pc !== target) && (n < limit)) begin  // idle instrs just step pc
      @(posedge clk);
      #2;
      n++;
    end
    if (pc !== target) begin
      abortRun($sformatf("timeout: pc did not reach %h within %0d cycles", target, limit));
    end
  endtask

  // entered 2 ns after an edge, leaves 2 ns after the next one
  task automatic execute(word_t ins, logic expEn, regIdx_t expReg, word_t expData, string what);
    instr = ins;
    @(negedge clk);  // wb outputs settled mid cycle
    checkBit(wbEn, expEn, {what, " wbEn"});
    if (expEn) begin
      checkReg(wbReg, expReg, {what, " wbReg"});
      checkWord(wbData, expData, {what, " wbData"});
      if (expReg != 5'd0) refRegs[expReg] = expData;  // r0 stays zero
    end
    @(posedge clk);
    #2;
    instr = idleInstr;
  endtask

  ////////////////////////////////////////////////////////////
  // instruction level tasks
  ////////////////////////////////////////////////////////////
  task automatic doImm(opcode_t op, regIdx_t rs, regIdx_t rt, logic [15:0] imm);
    word_t a;
    word_t sx;
    word_t zx;
    word_t exp;
    a  = refRegs[rs];
    sx = {{16{imm[15]}}, imm};
    zx = {16'h0000, imm};  // logic ops zero extend
    case (op)
      opAndi:  exp = a & zx;
      opOri:   exp = a | zx;
      opXori:  exp = a ^ zx;
      opSlti:  exp = ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
      default: exp = a + sx;
    endcase
    execute(encI(op, rs, rt, imm), 1'b1, rt, exp, "immediate op");
  endtask

  task automatic doReg(opcode_t op, logic [5:0] fn, regIdx_t rs, regIdx_t rt, regIdx_t rd);
    word_t a;
    word_t b;
    word_t exp;
    logic signed [63:0] prod;
    a    = refRegs[rs];
    b    = refRegs[rt];
    prod = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
    if (op == opSpecial2) begin
      exp = prod[31:0];  // low word of signed product
    end else begin
      case (fn)
        functAdd: exp = a + b;
        functSub: exp = a - b;
        functAnd: exp = a & b;
        functOr:  exp = a | b;
        functXor: exp = a ^ b;
        default:  exp = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      endcase
    end
    execute(encR(op, rs, rt, rd, fn), 1'b1, rd, exp, "register op");
  endtask

  // needs r30 = 0x10000, no lui or shifts available
  task automatic loadConst(regIdx_t rd, word_t value);
    doImm(opOri, 5'd0, rd, value[31:16]);
    doReg(opSpecial2, functMul, rd, 5'd30, rd);
    doImm(opOri, rd, rd, value[15:0]);
  endtask

  task automatic doStore(opcode_t op, regIdx_t rt, logic [15:0] off);
    word_t      addr;
    word_t      v;
    logic [9:0] ba;
    addr = refRegs[1] + {{16{off[15]}}, off};  // base always r1
    v    = refRegs[rt];
    ba   = addr[9:0];
    memRef[ba] = v[7:0];
    if (op != opSb) memRef[ba + 10'd1] = v[15:8];
    if (op == opSw) begin
      memRef[ba + 10'd2] = v[23:16];
      memRef[ba + 10'd3] = v[31:24];
    end
    execute(encI(op, 5'd1, rt, off), 1'b0, 5'd0, 32'd0, "store");
  endtask

  task automatic doLoad(opcode_t op, regIdx_t rt, logic [15:0] off);
    word_t      addr;
    word_t      exp;
    logic [9:0] ba;
    addr = refRegs[1] + {{16{off[15]}}, off};
    ba   = addr[9:0];
    case (op)
      opLb:    exp = {{24{memRef[ba][7]}}, memRef[ba]};
      opLh:    exp = {{16{memRef[ba + 10'd1][7]}}, memRef[ba + 10'd1], memRef[ba]};
      default: exp = {memRef[ba + 10'd3], memRef[ba + 10'd2], memRef[ba + 10'd1], memRef[ba]};
    endcase
    execute(encI(op, 5'd1, rt, off), 1'b1, rt, exp, "load");
  endtask

  task automatic doBranch(opcode_t op, regIdx_t rs, regIdx_t rt, logic [15:0] off);
    word_t start;
    word_t target;
    word_t a;
    logic  tk;
    start = pc;
    a     = refRegs[rs];
    case (op)
      opBeq:   tk = (a == refRegs[rt]);
      opBne:   tk = (a != refRegs[rt]);
      opBgtz:  tk = ($signed(a) > 0);
      opBlez:  tk = ($signed(a) <= 0);
      default: tk = rt[0] ? ($signed(a) >= 0) : ($signed(a) < 0);  // bgez : bltz
    endcase
    target = start + 32'd4;
    if (tk) target = target + {{14{off[15]}}, off, 2'b00};
    execute(encI(op, rs, rt, off), 1'b0, 5'd0, 32'd0, "branch");
    checkWord(pc, target, "branch next pc");
  endtask

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////
  task automatic resetTest();
    for (int i = 0; i < 16; i++) begin
      @(negedge clk);
      checkWord(pc, '0, "pc in reset");
      checkBit(wbEn, 1'b0, "wbEn in reset");
      @(posedge clk);
      #2;
    end
    rstN = 1'b1;
    @(negedge clk);
    checkWord(pc, '0, "pc after reset");
    checkBit(wbEn, 1'b0, "wbEn after reset");
    @(posedge clk);
    #2;
    waitForPc(32'd16, 8);  // sequential fetch running
  endtask

  task automatic arithTests();
    doImm(opAddi, 5'd0, 5'd8, randHalf());
    doImm(opAndi, 5'd8, 5'd9, randHalf());
    doImm(opOri,  5'd8, 5'd10, randHalf());
    doImm(opXori, 5'd9, 5'd11, randHalf());
    doImm(opSlti, 5'd8, 5'd12, randHalf());
    doImm(opAddi, 5'd8, 5'd0, randHalf());  // r0 write dropped
    doReg(opSpecial, functAdd, 5'd8, 5'd10, 5'd13);
    doReg(opSpecial, functSub, 5'd9, 5'd11, 5'd14);
    doReg(opSpecial, functAnd, 5'd10, 5'd13, 5'd15);
    doReg(opSpecial, functOr,  5'd11, 5'd14, 5'd16);
    doReg(opSpecial, functXor, 5'd13, 5'd14, 5'd17);
    doReg(opSpecial, functSlt, 5'd8, 5'd10, 5'd18);
    doReg(opSpecial, functSlt, 5'd14, 5'd13, 5'd19);
    doReg(opSpecial, functAdd, 5'd0, 5'd8, 5'd20);  // r0 reads zero
  endtask

  task automatic mulTest();
    doImm(opOri, 5'd0, 5'd30, 16'd256);
    doReg(opSpecial2, functMul, 5'd30, 5'd30, 5'd30);  // r30 = 0x10000
    loadConst(5'd22, randWord());
    loadConst(5'd23, randWord());
    doReg(opSpecial2, functMul, 5'd22, 5'd23, 5'd24);
  endtask

  task automatic memoryTests();
    doImm(opAddi, 5'd0, 5'd1, 16'd64);  // base address
    loadConst(5'd2, randWord());
    loadConst(5'd3, randWord());
    loadConst(5'd4, randWord());
    doStore(opSw, 5'd2, 16'd0);
    doStore(opSw, 5'd3, 16'd8);
    doStore(opSh, 5'd4, 16'd2);
    doStore(opSb, 5'd3, 16'd1);
    doStore(opSb, 5'd2, 16'd11);
    doStore(opSh, 5'd4, 16'd8);
    doLoad(opLw, 5'd21, 16'd0);
    doLoad(opLh, 5'd22, 16'd2);
    doLoad(opLh, 5'd23, 16'd0);
    doLoad(opLb, 5'd24, 16'd1);
    doLoad(opLb, 5'd25, 16'd3);
    doLoad(opLw, 5'd26, 16'd8);
    doLoad(opLb, 5'd27, 16'd11);
    doLoad(opLh, 5'd28, 16'd10);
  endtask

  task automatic branchTests();
    doImm(opAddi, 5'd0, 5'd5, 16'd5);
    doImm(opAddi, 5'd0, 5'd6, 16'hFFFD);  // -3
    doImm(opAddi, 5'd0, 5'd7, 16'd5);
    doBranch(opBeq,    5'd5, 5'd7, 16'd3);
    doBranch(opBeq,    5'd5, 5'd6, 16'd3);
    doBranch(opBne,    5'd5, 5'd6, 16'hFFFE);
    doBranch(opBne,    5'd5, 5'd7, 16'hFFFE);
    doBranch(opBgtz,   5'd5, 5'd0, 16'd7);
    doBranch(opBgtz,   5'd0, 5'd0, 16'd7);
    doBranch(opBlez,   5'd6, 5'd0, 16'hFFFC);
    doBranch(opBlez,   5'd5, 5'd0, 16'hFFFC);
    doBranch(opRegImm, 5'd0, 5'd1, 16'd5);  // bgez
    doBranch(opRegImm, 5'd6, 5'd1, 16'd5);
    doBranch(opRegImm, 5'd6, 5'd0, 16'd9);  // bltz
    doBranch(opRegImm, 5'd5, 5'd0, 16'd9);
  endtask

  task automatic jumpTests();
    word_t next;
    next = pc + 32'd4;
    execute(encJ(opJ, 26'h40), 1'b0, 5'd0, 32'd0, "j");
    checkWord(pc, {next[31:28], 26'h40, 2'b00}, "j target");
    next = pc + 32'd4;
    execute(encJ(opJal, 26'h90), 1'b1, 5'd31, next, "jal");
    checkWord(pc, {next[31:28], 26'h90, 2'b00}, "jal target");
    execute(encR(opSpecial, 5'd31, 5'd0, 5'd0, functJr), 1'b0, 5'd0, 32'd0, "jr");
    checkWord(pc, refRegs[31], "jr target");
    waitForPc(refRegs[31] + 32'd12, 8);
  endtask

  initial begin
    clk   = 1'b0;
    rstN  = 1'b0;
    instr = idleInstr;
    lfsr  = 16'd19;
    for (int i = 0; i < 32; i++) begin
      refRegs[i] = '0;
    end
    resetTest();
    arithTests();
    mulTest();
    memoryTests();
    branchTests();
    jumpTests();
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
logic/mipsPkg.sv
logic/controller.sv
logic/aluUnit.sv
logic/regFile.sv
logic/dataMem.sv
logic/pcUnit.sv
logic/mipsCore.sv
test/mipsCoreTb.sv

//--- run.sh
#!/bin/sh
# compile and run the testbench with Verilator; exit status is the result
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f filelist.f --top-module mipsCoreTb -o simv

./obj_dir/simv
